/* hw/datapath_pkg.sv */
// Datapath widths, I/O address map, ALU operation type, word types and address helpers
`default_nettype none

package datapath_pkg;

    // ------------------------------
    // Data words
    // ------------------------------

    localparam int WORD_WIDTH = 36;

    typedef logic [WORD_WIDTH-1:0] word_t;

    // ------------------------------
    // Memory addressing
    // ------------------------------

    localparam int MEM_ADDR_WIDTH   = 10;
    // Top bit picks the bank, 0 for A and 1 for B
    localparam int WRITE_ADDR_WIDTH = MEM_ADDR_WIDTH + 1;
    localparam int MEM_DEPTH        = 2 ** MEM_ADDR_WIDTH;

    typedef logic [MEM_ADDR_WIDTH-1:0]   mem_addr_t;
    typedef logic [WRITE_ADDR_WIDTH-1:0] write_addr_t;

    // ------------------------------
    // Memory-mapped I/O ports
    // ------------------------------

    localparam int IO_PORT_COUNT      = 4;
    localparam int IO_PORT_ADDR_WIDTH = 2;
    // Ports shadow the last words of each bank
    localparam int IO_PORT_BASE_ADDR  = MEM_DEPTH - IO_PORT_COUNT;

    typedef logic [IO_PORT_COUNT-1:0]            io_mask_t;
    typedef logic [IO_PORT_ADDR_WIDTH-1:0]       io_port_t;
    // Flat read data, port 0 in the low word
    typedef logic [IO_PORT_COUNT*WORD_WIDTH-1:0] io_data_t;

    // ------------------------------
    // ALU operations
    // ------------------------------

    typedef enum logic [2:0] {
        ALU_ADD    = 3'd0,
        ALU_SUB    = 3'd1,
        ALU_AND    = 3'd2,
        ALU_OR     = 3'd3,
        ALU_XOR    = 3'd4,
        ALU_PASS_A = 3'd5,
        ALU_PASS_B = 3'd6
    } alu_op_t;

    // Address falls in the I/O window of a bank
    function automatic logic is_io_addr(input mem_addr_t addr);
        return addr >= mem_addr_t'(IO_PORT_BASE_ADDR);
    endfunction

    // Port number within the I/O window
    function automatic io_port_t io_port_index(input mem_addr_t addr);
        mem_addr_t offset;
        offset = addr - mem_addr_t'(IO_PORT_BASE_ADDR);
        return offset[IO_PORT_ADDR_WIDTH-1:0];
    endfunction

endpackage

`default_nettype wire

/* hw/delay_line.sv */
// Shift register of any payload type, cleared on reset
`timescale 1ns/100ps
`default_nettype none

module delay_line #(
    parameter type T     = logic,
    parameter int  DEPTH = 1
) (
    input  wire  clock,
    input  wire  rst_n,
    input  T     in_data,
    output T     out_data
);

    T stages [DEPTH];

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                stages[i] <= T'(0);
            end
        end else begin
            stages[0] <= in_data;
            for (int i = 1; i < DEPTH; i++) begin
                stages[i] <= stages[i-1];
            end
        end
    end

    assign out_data = stages[DEPTH-1];

    // A zero-length line has no registers to hold the payload
    if (DEPTH < 1) begin : g_depth_check
        $error("delay_line needs DEPTH of at least 1");
    end

endmodule

`default_nettype wire

/* hw/io_predication.sv */
// I/O address decode, empty/full check, annul decision and registered read enables
`timescale 1ns/100ps
`default_nettype none

module io_predication
    import datapath_pkg::*;
(
    input  wire         clock,
    input  wire         rst_n,
    input  wire         instr_valid,
    input  mem_addr_t   read_addr_a,
    input  mem_addr_t   read_addr_b,
    input  write_addr_t write_addr,
    input  io_mask_t    io_read_ef_a,
    input  io_mask_t    io_read_ef_b,
    input  io_mask_t    io_write_ef_a,
    input  io_mask_t    io_write_ef_b,
    output io_mask_t    io_rden_a,
    output io_mask_t    io_rden_b,
    output logic        read_is_io_a,
    output logic        read_is_io_b,
    output logic        write_is_io,
    output logic        instr_ready
);

    logic      rd_io_a;
    logic      rd_io_b;
    io_port_t  rd_port_a;
    io_port_t  rd_port_b;
    mem_addr_t wr_local;
    io_port_t  wr_port;
    io_mask_t  wr_ef;
    logic      ok_a;
    logic      ok_b;
    logic      ok_w;

    // ------------------------------
    // Decode and predication rule
    // ------------------------------

    assign rd_io_a   = is_io_addr(read_addr_a);
    assign rd_io_b   = is_io_addr(read_addr_b);
    assign rd_port_a = io_port_index(read_addr_a);
    assign rd_port_b = io_port_index(read_addr_b);

    assign wr_local    = write_addr[MEM_ADDR_WIDTH-1:0];
    assign write_is_io = is_io_addr(wr_local);
    assign wr_port     = io_port_index(wr_local);
    // Write side follows the bank bit
    assign wr_ef = write_addr[WRITE_ADDR_WIDTH-1] ? io_write_ef_b : io_write_ef_a;

    // Reads need data waiting, writes need room
    assign ok_a = !rd_io_a || io_read_ef_a[rd_port_a];
    assign ok_b = !rd_io_b || io_read_ef_b[rd_port_b];
    assign ok_w = !write_is_io || wr_ef[wr_port];

    assign instr_ready = instr_valid && ok_a && ok_b && ok_w;

    // ------------------------------
    // Registered enables and flags
    // ------------------------------

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            io_rden_a    <= '0;
            io_rden_b    <= '0;
            read_is_io_a <= 1'b0;
            read_is_io_b <= 1'b0;
        end else begin
            io_rden_a    <= (instr_ready && rd_io_a) ? io_mask_t'(1) << rd_port_a : '0;
            io_rden_b    <= (instr_ready && rd_io_b) ? io_mask_t'(1) << rd_port_b : '0;
            read_is_io_a <= rd_io_a;
            read_is_io_b <= rd_io_b;
        end
    end

    // One port at most per side and instruction
    assert property (@(posedge clock) disable iff (!rst_n) $onehot0(io_rden_a));
    assert property (@(posedge clock) disable iff (!rst_n) $onehot0(io_rden_b));

endmodule

`default_nettype wire

/* hw/data_memory.sv */
// One data bank with RAM, I/O read selection and the split of writes between RAM and I/O
`timescale 1ns/100ps
`default_nettype none

module data_memory
    import datapath_pkg::*;
#(
    parameter int BANK = 0
) (
    input  wire         clock,
    input  wire         rst_n,
    input  mem_addr_t   read_addr,
    input  wire         read_is_io,
    input  io_data_t    io_read_data,
    input  wire         write_valid,
    input  write_addr_t write_addr,
    input  wire         write_is_io,
    input  word_t       write_data,
    output word_t       read_data,
    output io_mask_t    io_wren,
    output word_t       io_write_data
);

    word_t     ram [MEM_DEPTH];
    word_t     ram_q;
    io_port_t  rd_port_q;
    word_t     io_word;
    mem_addr_t wr_local;
    io_port_t  wr_port;
    logic      bank_hit;
    logic      ram_we;
    logic      io_we;

    // Banks power up cleared
    initial begin
        for (int i = 0; i < MEM_DEPTH; i++) begin
            ram[i] = '0;
        end
    end

    // ------------------------------
    // Read side
    // ------------------------------

    // Same-edge read and write returns the old word
    always_ff @(posedge clock) begin
        ram_q     <= ram[read_addr];
        rd_port_q <= io_port_index(read_addr);
        if (ram_we) begin
            ram[wr_local] <= write_data;
        end
    end

    assign io_word = io_read_data[rd_port_q*WORD_WIDTH +: WORD_WIDTH];

    // Port data is sampled in the cycle its read enable is out
    always_ff @(posedge clock) begin
        read_data <= read_is_io ? io_word : ram_q;
    end

    // ------------------------------
    // Write side
    // ------------------------------

    assign wr_local = write_addr[MEM_ADDR_WIDTH-1:0];
    assign wr_port  = io_port_index(wr_local);
    assign bank_hit = (write_addr[WRITE_ADDR_WIDTH-1] == 1'(BANK));
    assign ram_we   = write_valid && bank_hit && !write_is_io;
    assign io_we    = write_valid && bank_hit && write_is_io;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            io_wren <= '0;
        end else begin
            io_wren <= io_we ? io_mask_t'(1) << wr_port : '0;
        end
    end

    // Shared write word is qualified by io_wren
    always_ff @(posedge clock) begin
        if (io_we) begin
            io_write_data <= write_data;
        end
    end

    assert property (@(posedge clock) disable iff (!rst_n) $onehot0(io_wren));

    // The delayed I/O flag must agree with the delayed address, so shadowed words stay untouched
    assert property (@(posedge clock) disable iff (!rst_n) ram_we |-> !is_io_addr(wr_local));

endmodule

`default_nettype wire

/* hw/triadic_alu.sv */
// ALU operations, carry and overflow flags, registered result
`timescale 1ns/100ps
`default_nettype none

module triadic_alu
    import datapath_pkg::*;
(
    input  wire     clock,
    input  wire     rst_n,
    input  alu_op_t op,
    input  wire     in_valid,
    input  word_t   a,
    input  word_t   b,
    output logic    out_valid,
    output word_t   r,
    output logic    carry_out,
    output logic    overflow
);

    localparam int MSB = WORD_WIDTH - 1;

    logic [WORD_WIDTH:0] sum;
    logic [WORD_WIDTH:0] diff;
    word_t               r_next;
    logic                carry_next;
    logic                overflow_next;

    assign sum  = {1'b0, a} + {1'b0, b};
    assign diff = {1'b0, a} - {1'b0, b};

    always_comb begin
        r_next        = '0;
        carry_next    = 1'b0;
        overflow_next = 1'b0;
        case (op)
            ALU_ADD: begin
                r_next        = sum[MSB:0];
                carry_next    = sum[WORD_WIDTH];
                overflow_next = (a[MSB] == b[MSB]) && (sum[MSB] != a[MSB]);
            end
            ALU_SUB: begin
                r_next        = diff[MSB:0];
                // No borrow means a >= b
                carry_next    = !diff[WORD_WIDTH];
                overflow_next = (a[MSB] != b[MSB]) && (diff[MSB] != a[MSB]);
            end
            ALU_AND:    r_next = a & b;
            ALU_OR:     r_next = a | b;
            ALU_XOR:    r_next = a ^ b;
            ALU_PASS_A: r_next = a;
            ALU_PASS_B: r_next = b;
            default:    r_next = '0;
        endcase
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clock) begin
        r         <= r_next;
        carry_out <= carry_next;
        overflow  <= overflow_next;
    end

    assert property (@(posedge clock) disable iff (!rst_n) in_valid |-> !$isunknown(op));

endmodule

`default_nettype wire

/* hw/datapath.sv */
// Datapath top: predication, banks A and B, ALU and the pipeline side channels
`timescale 1ns/100ps
`default_nettype none

module datapath
    import datapath_pkg::*;
(
    input  wire         clock,
    input  wire         rst_n,

    // Instruction strobe and fields
    input  wire         instr_valid,
    input  alu_op_t     op,
    input  mem_addr_t   read_addr_a,
    input  mem_addr_t   read_addr_b,
    input  write_addr_t write_addr,

    // I/O port status and data
    input  io_mask_t    io_read_ef_a,
    input  io_mask_t    io_read_ef_b,
    input  io_mask_t    io_write_ef_a,
    input  io_mask_t    io_write_ef_b,
    input  io_data_t    io_read_data_a,
    input  io_data_t    io_read_data_b,
    output io_mask_t    io_rden_a,
    output io_mask_t    io_rden_b,
    output io_mask_t    io_wren_a,
    output io_mask_t    io_wren_b,
    output word_t       io_write_data_a,
    output word_t       io_write_data_b,

    // Write-back result
    output logic        result_valid,
    output word_t       result,
    output write_addr_t result_addr,
    output logic        result_carry,
    output logic        result_overflow
);

    typedef struct packed {
        logic        is_io;
        write_addr_t addr;
    } write_tag_t;

    logic       read_is_io_a;
    logic       read_is_io_b;
    logic       write_is_io;
    logic       instr_ready;
    logic       ready_alu;
    alu_op_t    op_alu;
    write_tag_t write_tag_in;
    write_tag_t write_tag_wb;
    word_t      operand_a;
    word_t      operand_b;

    // ------------------------------
    // Issue, cycle t
    // ------------------------------

    io_predication predication_i (
        .clock         (clock),
        .rst_n         (rst_n),
        .instr_valid   (instr_valid),
        .read_addr_a   (read_addr_a),
        .read_addr_b   (read_addr_b),
        .write_addr    (write_addr),
        .io_read_ef_a  (io_read_ef_a),
        .io_read_ef_b  (io_read_ef_b),
        .io_write_ef_a (io_write_ef_a),
        .io_write_ef_b (io_write_ef_b),
        .io_rden_a     (io_rden_a),
        .io_rden_b     (io_rden_b),
        .read_is_io_a  (read_is_io_a),
        .read_is_io_b  (read_is_io_b),
        .write_is_io   (write_is_io),
        .instr_ready   (instr_ready)
    );

    // Side channels: op and valid meet the operands at t+2, address meets the result at t+3
    delay_line #(.T(alu_op_t), .DEPTH(2)) op_delay_i (
        .clock    (clock),
        .rst_n    (rst_n),
        .in_data  (op),
        .out_data (op_alu)
    );

    delay_line #(.T(logic), .DEPTH(2)) ready_delay_i (
        .clock    (clock),
        .rst_n    (rst_n),
        .in_data  (instr_ready),
        .out_data (ready_alu)
    );

    assign write_tag_in = '{is_io: write_is_io, addr: write_addr};

    delay_line #(.T(write_tag_t), .DEPTH(3)) write_delay_i (
        .clock    (clock),
        .rst_n    (rst_n),
        .in_data  (write_tag_in),
        .out_data (write_tag_wb)
    );

    // ------------------------------
    // Operand read and write-back
    // ------------------------------

    data_memory #(.BANK(0)) bank_a_i (
        .clock         (clock),
        .rst_n         (rst_n),
        .read_addr     (read_addr_a),
        .read_is_io    (read_is_io_a),
        .io_read_data  (io_read_data_a),
        .write_valid   (result_valid),
        .write_addr    (write_tag_wb.addr),
        .write_is_io   (write_tag_wb.is_io),
        .write_data    (result),
        .read_data     (operand_a),
        .io_wren       (io_wren_a),
        .io_write_data (io_write_data_a)
    );

    data_memory #(.BANK(1)) bank_b_i (
        .clock         (clock),
        .rst_n         (rst_n),
        .read_addr     (read_addr_b),
        .read_is_io    (read_is_io_b),
        .io_read_data  (io_read_data_b),
        .write_valid   (result_valid),
        .write_addr    (write_tag_wb.addr),
        .write_is_io   (write_tag_wb.is_io),
        .write_data    (result),
        .read_data     (operand_b),
        .io_wren       (io_wren_b),
        .io_write_data (io_write_data_b)
    );

    // ------------------------------
    // ALU, result at t+3
    // ------------------------------

    triadic_alu alu_i (
        .clock     (clock),
        .rst_n     (rst_n),
        .op        (op_alu),
        .in_valid  (ready_alu),
        .a         (operand_a),
        .b         (operand_b),
        .out_valid (result_valid),
        .r         (result),
        .carry_out (result_carry),
        .overflow  (result_overflow)
    );

    assign result_addr = write_tag_wb.addr;

endmodule

`default_nettype wire

/* bench/datapath_model.svh */
// Reference model: bank contents, predication rule, ALU rule and expected events per cycle
`ifndef DATAPATH_MODEL_SVH
`define DATAPATH_MODEL_SVH

localparam int     MODEL_CYCLES = 4400;
localparam longint SIGNED_MAX   = (longint'(1) <<< (WORD_WIDTH - 1)) - 1;
localparam longint SIGNED_MIN   = -(longint'(1) <<< (WORD_WIDTH - 1));

// Bank contents, all zero at start like the DUT RAM
bit [WORD_WIDTH-1:0] model_mem_a [MEM_DEPTH];
bit [WORD_WIDTH-1:0] model_mem_b [MEM_DEPTH];

// Expected outputs, indexed by cycle number
bit                        exp_valid  [MODEL_CYCLES];
bit [WORD_WIDTH-1:0]       exp_result [MODEL_CYCLES];
bit [WRITE_ADDR_WIDTH-1:0] exp_addr   [MODEL_CYCLES];
bit                        exp_carry  [MODEL_CYCLES];
bit                        exp_ovf    [MODEL_CYCLES];
bit [IO_PORT_COUNT-1:0]    exp_rden_a [MODEL_CYCLES];
bit [IO_PORT_COUNT-1:0]    exp_rden_b [MODEL_CYCLES];
bit [IO_PORT_COUNT-1:0]    exp_wren_a [MODEL_CYCLES];
bit [IO_PORT_COUNT-1:0]    exp_wren_b [MODEL_CYCLES];

// ------------------------------
// ALU rule
// ------------------------------

task automatic alu_eval(
    input  alu_op_t op,
    input  word_t   a,
    input  word_t   b,
    output word_t   r,
    output bit      carry,
    output bit      ovf
);
    logic [63:0] usum;
    longint      ssum;

    r     = '0;
    carry = 1'b0;
    ovf   = 1'b0;
    case (op)
        ALU_ADD: begin
            usum  = 64'(a) + 64'(b);
            ssum  = longint'($signed(a)) + longint'($signed(b));
            r     = word_t'(usum);
            carry = usum[WORD_WIDTH];
            ovf   = (ssum > SIGNED_MAX) || (ssum < SIGNED_MIN);
        end
        ALU_SUB: begin
            ssum  = longint'($signed(a)) - longint'($signed(b));
            r     = a - b;
            // Set when no borrow is needed
            carry = (a >= b);
            ovf   = (ssum > SIGNED_MAX) || (ssum < SIGNED_MIN);
        end
        ALU_AND: begin
            r = a & b;
        end
        ALU_OR: begin
            r = a | b;
        end
        ALU_XOR: begin
            r = a ^ b;
        end
        ALU_PASS_A: begin
            r = a;
        end
        ALU_PASS_B: begin
            r = b;
        end
        default: begin
            r = '0;
        end
    endcase
endtask

// ------------------------------
// Issue and write-back
// ------------------------------

// Instruction issued in cycle t; port data is what the ports show in cycle t+1
task automatic model_issue(
    input int          t,
    input alu_op_t     op_v,
    input mem_addr_t   ra,
    input mem_addr_t   rb,
    input write_addr_t wa,
    input io_mask_t    rd_ef_a,
    input io_mask_t    rd_ef_b,
    input io_mask_t    wr_ef_a,
    input io_mask_t    wr_ef_b,
    input io_data_t    io_next_a,
    input io_data_t    io_next_b
);
    bit                          io_ra;
    bit                          io_rb;
    bit                          io_w;
    bit                          side_b;
    bit [IO_PORT_ADDR_WIDTH-1:0] pa;
    bit [IO_PORT_ADDR_WIDTH-1:0] pb;
    bit [IO_PORT_ADDR_WIDTH-1:0] pw;
    mem_addr_t                   wl;
    word_t                       a;
    word_t                       b;
    word_t                       r;
    bit                          carry;
    bit                          ovf;

    wl     = wa[MEM_ADDR_WIDTH-1:0];
    side_b = wa[WRITE_ADDR_WIDTH-1];
    io_ra  = ra >= mem_addr_t'(IO_PORT_BASE_ADDR);
    io_rb  = rb >= mem_addr_t'(IO_PORT_BASE_ADDR);
    io_w   = wl >= mem_addr_t'(IO_PORT_BASE_ADDR);
    // Window starts on a multiple of the port count
    pa = ra[IO_PORT_ADDR_WIDTH-1:0];
    pb = rb[IO_PORT_ADDR_WIDTH-1:0];
    pw = wl[IO_PORT_ADDR_WIDTH-1:0];

    // Annulled instructions leave no trace at all
    if (io_ra && !rd_ef_a[pa]) begin
        return;
    end
    if (io_rb && !rd_ef_b[pb]) begin
        return;
    end
    if (io_w && !(side_b ? wr_ef_b[pw] : wr_ef_a[pw])) begin
        return;
    end

    if (io_ra) begin
        a = io_next_a[pa*WORD_WIDTH +: WORD_WIDTH];
        exp_rden_a[t+1][pa] = 1'b1;
    end else begin
        a = model_mem_a[ra];
    end
    if (io_rb) begin
        b = io_next_b[pb*WORD_WIDTH +: WORD_WIDTH];
        exp_rden_b[t+1][pb] = 1'b1;
    end else begin
        b = model_mem_b[rb];
    end

    alu_eval(op_v, a, b, r, carry, ovf);
    exp_valid[t+3]  = 1'b1;
    exp_result[t+3] = r;
    exp_addr[t+3]   = wa;
    exp_carry[t+3]  = carry;
    exp_ovf[t+3]    = ovf;

    if (io_w && side_b) begin
        exp_wren_b[t+4][pw] = 1'b1;
    end else if (io_w) begin
        exp_wren_a[t+4][pw] = 1'b1;
    end
endtask

// Result of cycle c-1 lands in the RAM at the edge that starts cycle c
task automatic model_commit(input int c);
    write_addr_t wa;
    mem_addr_t   local_addr;

    if (c < 1 || !exp_valid[c-1]) begin
        return;
    end
    wa         = exp_addr[c-1];
    local_addr = wa[MEM_ADDR_WIDTH-1:0];
    // Port writes leave the shadowed RAM word alone
    if (local_addr >= mem_addr_t'(IO_PORT_BASE_ADDR)) begin
        return;
    end
    if (wa[WRITE_ADDR_WIDTH-1]) begin
        model_mem_b[local_addr] = exp_result[c-1];
    end else begin
        model_mem_a[local_addr] = exp_result[c-1];
    end
endtask

`endif

/* bench/datapath_tb.sv */
// Datapath testbench with clock, reset, random instructions, I/O port emulation, checks and watchdog
`timescale 1ns/100ps
`default_nettype none

module datapath_tb
    import datapath_pkg::*;
();

    localparam int CLOCK_PERIOD = 4;
    localparam int NUM_INSTR    = 2000;
    localparam int DRAIN_CYCLES = 6;
    localparam int WATCHDOG_NS  = (NUM_INSTR * 2 + 100) * CLOCK_PERIOD;

    logic        clock;
    logic        rst_n;
    logic        instr_valid;
    alu_op_t     op;
    mem_addr_t   read_addr_a;
    mem_addr_t   read_addr_b;
    write_addr_t write_addr;
    io_mask_t    io_read_ef_a;
    io_mask_t    io_read_ef_b;
    io_mask_t    io_write_ef_a;
    io_mask_t    io_write_ef_b;
    io_data_t    io_read_data_a;
    io_data_t    io_read_data_b;
    io_mask_t    io_rden_a;
    io_mask_t    io_rden_b;
    io_mask_t    io_wren_a;
    io_mask_t    io_wren_b;
    word_t       io_write_data_a;
    word_t       io_write_data_b;
    logic        result_valid;
    word_t       result;
    write_addr_t result_addr;
    logic        result_carry;
    logic        result_overflow;

    int seed           = 32'hb652;
    int cyc            = 0;
    int mismatch_count = 0;
    int pulse_count    = 0;

    `include "datapath_model.svh"

    datapath datapath_i (
        .clock           (clock),
        .rst_n           (rst_n),
        .instr_valid     (instr_valid),
        .op              (op),
        .read_addr_a     (read_addr_a),
        .read_addr_b     (read_addr_b),
        .write_addr      (write_addr),
        .io_read_ef_a    (io_read_ef_a),
        .io_read_ef_b    (io_read_ef_b),
        .io_write_ef_a   (io_write_ef_a),
        .io_write_ef_b   (io_write_ef_b),
        .io_read_data_a  (io_read_data_a),
        .io_read_data_b  (io_read_data_b),
        .io_rden_a       (io_rden_a),
        .io_rden_b       (io_rden_b),
        .io_wren_a       (io_wren_a),
        .io_wren_b       (io_wren_b),
        .io_write_data_a (io_write_data_a),
        .io_write_data_b (io_write_data_b),
        .result_valid    (result_valid),
        .result          (result),
        .result_addr     (result_addr),
        .result_carry    (result_carry),
        .result_overflow (result_overflow)
    );

    // ------------------------------
    // Random stimulus helpers
    // ------------------------------

    function automatic word_t rand_word();
        return word_t'({$random(seed), $random(seed)});
    endfunction

    function automatic io_data_t rand_io_data();
        io_data_t data;
        for (int i = 0; i < IO_PORT_COUNT; i++) begin
            data[i*WORD_WIDTH +: WORD_WIDTH] = rand_word();
        end
        return data;
    endfunction

    // Most ports are ready so most instructions go through
    function automatic io_mask_t rand_ef();
        return io_mask_t'($random(seed) | $random(seed));
    endfunction

    // About one in four hits the I/O window and the rest reuse a few low words
    function automatic mem_addr_t rand_addr();
        if (($random(seed) & 3) == 0) begin
            return mem_addr_t'(IO_PORT_BASE_ADDR + ($random(seed) & 3));
        end
        return mem_addr_t'($random(seed) & 15);
    endfunction

    // ------------------------------
    // Checks
    // ------------------------------

    task automatic check_field(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp) else begin
            mismatch_count++;
            $display("mismatch at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic check_enable(input string name, input io_mask_t got, input io_mask_t exp);
        assert (exp != '0 || got === '0) else begin
            pulse_count++;
            $display("unexpected pulse on %s at %0t ns, value %0h", name, $time, got);
        end
        if (exp != '0) begin
            check_field(name, 64'(got), 64'(exp));
        end
    endtask

    task automatic check_outputs(input int c);
        check_field("result_valid", 64'(result_valid), 64'(exp_valid[c]));
        if (exp_valid[c]) begin
            check_field("result", 64'(result), 64'(exp_result[c]));
            check_field("result_addr", 64'(result_addr), 64'(exp_addr[c]));
            check_field("result_carry", 64'(result_carry), 64'(exp_carry[c]));
            check_field("result_overflow", 64'(result_overflow), 64'(exp_ovf[c]));
        end
        check_enable("io_rden_a", io_rden_a, exp_rden_a[c]);
        check_enable("io_rden_b", io_rden_b, exp_rden_b[c]);
        check_enable("io_wren_a", io_wren_a, exp_wren_a[c]);
        check_enable("io_wren_b", io_wren_b, exp_wren_b[c]);
        // Port write data follows the result by one cycle
        if (exp_wren_a[c] != '0) begin
            check_field("io_write_data_a", 64'(io_write_data_a), 64'(exp_result[c-1]));
        end
        if (exp_wren_b[c] != '0) begin
            check_field("io_write_data_b", 64'(io_write_data_b), 64'(exp_result[c-1]));
        end
    endtask

    // Outputs are settled at the falling edge
    initial begin
        forever begin
            @(negedge clock);
            if (rst_n) begin
                check_outputs(cyc);
            end
        end
    end

    // ------------------------------
    // Clock, reset and instruction stream
    // ------------------------------

    initial begin
        clock = 1'b0;
        forever begin
            #(CLOCK_PERIOD / 2) clock = ~clock;
        end
    end

    initial begin
        int          issued;
        int          drain;
        bit          issue;
        alu_op_t     op_v;
        mem_addr_t   ra;
        mem_addr_t   rb;
        write_addr_t wa;
        io_mask_t    ef_ra;
        io_mask_t    ef_rb;
        io_mask_t    ef_wa;
        io_mask_t    ef_wb;
        io_data_t    io_next_a;
        io_data_t    io_next_b;

        rst_n          = 1'b0;
        instr_valid    = 1'b0;
        op             = ALU_ADD;
        read_addr_a    = '0;
        read_addr_b    = '0;
        write_addr     = '0;
        io_read_ef_a   = '0;
        io_read_ef_b   = '0;
        io_write_ef_a  = '0;
        io_write_ef_b  = '0;
        io_read_data_a = '0;
        io_read_data_b = '0;
        issued         = 0;
        drain          = 0;
        io_next_a      = rand_io_data();
        io_next_b      = rand_io_data();

        repeat (2) @(posedge clock);
        rst_n <= 1'b1;

        while (issued < NUM_INSTR || drain < DRAIN_CYCLES) begin
            @(posedge clock);
            cyc = cyc + 1;
            model_commit(cyc);

            // Port data for this cycle was drawn one cycle ahead
            io_read_data_a <= io_next_a;
            io_read_data_b <= io_next_b;
            io_next_a = rand_io_data();
            io_next_b = rand_io_data();

            ef_ra = rand_ef();
            ef_rb = rand_ef();
            ef_wa = rand_ef();
            ef_wb = rand_ef();
            io_read_ef_a  <= ef_ra;
            io_read_ef_b  <= ef_rb;
            io_write_ef_a <= ef_wa;
            io_write_ef_b <= ef_wb;

            issue = (issued < NUM_INSTR) && (($random(seed) & 3) != 0);
            instr_valid <= issue;
            if (issue) begin
                op_v = alu_op_t'(($random(seed) & 32'h7fffffff) % 7);
                ra   = rand_addr();
                rb   = rand_addr();
                wa   = {1'($random(seed)), rand_addr()};
                op          <= op_v;
                read_addr_a <= ra;
                read_addr_b <= rb;
                write_addr  <= wa;
                model_issue(cyc, op_v, ra, rb, wa, ef_ra, ef_rb, ef_wa, ef_wb,
                            io_next_a, io_next_b);
                issued++;
            end else if (issued == NUM_INSTR) begin
                drain++;
            end
        end
        // The last cycle is checked at the falling edge before this one
        @(posedge clock);

        $display("errors: %0d mismatches, %0d unexpected pulses over %0d instructions",
                 mismatch_count, pulse_count, issued);
        if (mismatch_count == 0 && pulse_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // Stops a run that never drains
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns with %0d mismatches, %0d unexpected pulses",
                 WATCHDOG_NS, mismatch_count, pulse_count);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
+incdir+bench
hw/datapath_pkg.sv
hw/delay_line.sv
hw/io_predication.sv
hw/data_memory.sv
hw/triadic_alu.sv
hw/datapath.sv
bench/datapath_tb.sv
